// ==== sim.f ====
+incdir+hdl
hdl/uart_pkg.sv
hdl/sync_parallel_counter.sv
hdl/fifo.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_fifo_top.sv
verification/uart_fifo_checker.sv
verification/tb_uart_fifo.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_uart_fifo -o tb_uart_fifo \
  && ./obj_dir/tb_uart_fifo | tee /dev/stderr | grep -q "All tests passed!" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

// ==== verification/tb_uart_fifo.sv ====
// ****************************************
// testbench for the uart peripheral
// loops txd back to rxd or drives hand-made frames
// checking lives in uart_fifo_checker
// ****************************************
`timescale 1ns/100ps
`include "uart_cfg.svh"

module tb_uart_fifo;

  localparam int CPB        = `UART_CLKS_PER_BIT;
  localparam int FRAME      = 10 * CPB;
  // 29 frames in all
  localparam int WATCHDOG_NS = 29 * FRAME * 4 + 20000;

  logic                   clock;
  logic                   rst_n;
  logic                   tx_enable;
  logic                   tx_wr_en;
  uart_pkg::uart_byte_t   tx_data;
  uart_pkg::tx_level_t    tx_level;
  logic                   rx_rd_en;
  uart_pkg::rx_level_t    rx_level;
  uart_pkg::uart_byte_t   rx_data;
  uart_pkg::uart_status_t status;
  logic                   frame_error;
  logic                   rx_overrun;
  logic                   txd;
  logic                   rxd;
  logic                   loopback;
  logic                   ovr_line;
  logic                   end_of_test;
  logic                   report_done;
  int                     checker_errors;
  int                     tb_errors;
  int                     seed_val;

  assign rxd = loopback ? txd : ovr_line;

  uart_fifo_top i_uart_fifo_top (
    .clock       (clock),
    .rst_n       (rst_n),
    .tx_enable   (tx_enable),
    .tx_wr_en    (tx_wr_en),
    .tx_data     (tx_data),
    .tx_level    (tx_level),
    .rx_rd_en    (rx_rd_en),
    .rx_level    (rx_level),
    .rx_data     (rx_data),
    .status      (status),
    .frame_error (frame_error),
    .rx_overrun  (rx_overrun),
    .txd         (txd),
    .rxd         (rxd)
  );

  uart_fifo_checker i_checker (
    .clock       (clock),
    .rst_n       (rst_n),
    .tx_enable   (tx_enable),
    .tx_wr_en    (tx_wr_en),
    .tx_data     (tx_data),
    .tx_level    (tx_level),
    .rx_rd_en    (rx_rd_en),
    .rx_level    (rx_level),
    .rx_data     (rx_data),
    .status      (status),
    .frame_error (frame_error),
    .rx_overrun  (rx_overrun),
    .txd         (txd),
    .rxd         (rxd),
    .loopback    (loopback),
    .end_of_test (end_of_test),
    .error_count (checker_errors),
    .report_done (report_done)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // all tasks start and end 1 ns after a rising edge
  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  task automatic push_byte(input uart_pkg::uart_byte_t b);
    tx_wr_en = 1'b1;
    tx_data  = b;
    next_cycle();
    tx_wr_en = 1'b0;
  endtask

  // line idle and tx queue drained for a few bit times
  task automatic wait_line_idle();
    int quiet;
    int waited;
    quiet  = 0;
    waited = 0;
    while (quiet < 3 * CPB && waited < 10 * FRAME) begin
      next_cycle();
      waited++;
      quiet = (status.tx_empty && txd && rxd) ? quiet + 1 : 0;
    end
    if (quiet < 3 * CPB) begin
      $display("timed out at %0t ns waiting for the serial line to go idle", $time);
      tb_errors++;
    end
  endtask

  task automatic send_queued();
    tx_enable = 1'b1;
    wait_line_idle();
    tx_enable = 1'b0;
  endtask

  task automatic drain_rx();
    int reads;
    reads = 0;
    while (!status.rx_empty && reads < 2 * `UART_RX_DEPTH) begin
      rx_rd_en = 1'b1;
      next_cycle();
      rx_rd_en = 1'b0;
      reads++;
    end
  endtask

  task automatic hold_bit(input logic level);
    ovr_line = level;
    repeat (CPB) next_cycle();
  endtask

  task automatic drive_frame(input uart_pkg::uart_byte_t b, input logic stop_bit);
    hold_bit(1'b0);
    for (int i = 0; i < `UART_DATA_BITS; i++) begin
      hold_bit(b[i]);
    end
    hold_bit(stop_bit);
    hold_bit(1'b1);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired, the run did not finish in time");
    $display("Test failures found");
    $finish;
  end

  initial begin
    seed_val    = $urandom(97);
    rst_n       = 1'b0;
    tx_enable   = 1'b0;
    tx_wr_en    = 1'b0;
    tx_data     = '0;
    tx_level    = 3'd7;
    rx_rd_en    = 1'b0;
    rx_level    = 4'd15;
    loopback    = 1'b1;
    ovr_line    = 1'b1;
    end_of_test = 1'b0;
    tb_errors   = 0;
    repeat (16) @(posedge clock);
    #1;
    rst_n = 1'b1;
    repeat (4) next_cycle();

    // 20 random bytes through the loop in batches sized to the tx watermark
    for (int batch = 0; batch < 3; batch++) begin
      for (int i = 0; i < ((batch == 2) ? 6 : 7); i++) begin
        push_byte(uart_pkg::uart_byte_t'($urandom));
      end
      send_queued();
      drain_rx();
    end

    // six pushes against a watermark of four
    tx_level = 3'd4;
    for (int i = 0; i < 6; i++) begin
      push_byte(uart_pkg::uart_byte_t'(8'h40 + i));
    end
    repeat (4) next_cycle();
    send_queued();
    drain_rx();

    // three frames into an rx queue limited to two
    tx_level = 3'd7;
    rx_level = 4'd2;
    for (int i = 0; i < 3; i++) begin
      push_byte(uart_pkg::uart_byte_t'(8'hc0 + i));
    end
    send_queued();
    drain_rx();

    // bad stop bit then a good frame
    rx_level = 4'd15;
    loopback = 1'b0;
    drive_frame(8'h5a, 1'b0);
    drive_frame(8'ha5, 1'b1);
    wait_line_idle();
    drain_rx();
    loopback = 1'b1;

    end_of_test = 1'b1;
    while (!report_done) next_cycle();
    $display("errors: checker %0d, testbench %0d", checker_errors, tb_errors);
    if (checker_errors == 0 && tb_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== verification/uart_fifo_checker.sv ====
// ****************************************
// scoreboard for the uart peripheral
// watches the DUT ports and models both queues and the serial line
// tb raises end_of_test and the checker answers with report_done
// ****************************************
`timescale 1ns/100ps
`include "uart_cfg.svh"

module uart_fifo_checker (
  input  logic                   clock,
  input  logic                   rst_n,
  input  logic                   tx_enable,
  input  logic                   tx_wr_en,
  input  uart_pkg::uart_byte_t   tx_data,
  input  uart_pkg::tx_level_t    tx_level,
  input  logic                   rx_rd_en,
  input  uart_pkg::rx_level_t    rx_level,
  input  uart_pkg::uart_byte_t   rx_data,
  input  uart_pkg::uart_status_t status,
  input  logic                   frame_error,
  input  logic                   rx_overrun,
  input  logic                   txd,
  input  logic                   rxd,
  input  logic                   loopback,
  input  logic                   end_of_test,
  output int                     error_count,
  output logic                   report_done
);

  localparam int CPB   = `UART_CLKS_PER_BIT;
  localparam int FRAME = 10 * CPB;

  // bytes accepted by the tx queue and bytes the rx queue should hold
  uart_pkg::uart_byte_t tx_exp[$];
  uart_pkg::uart_byte_t rx_exp[$];
  uart_pkg::uart_byte_t dec_byte;
  uart_pkg::uart_byte_t exp_byte;
  int tx_cnt;
  int rx_cnt;
  int tx_busy;
  int dec_cnt;
  int rx_quiet;
  int ferr_exp;
  int ferr_seen;
  int ovr_exp;
  int ovr_seen;
  logic txd_prev;
  logic rxd_prev;
  logic reset_checked;

  // queue accepts a push while below its watermark
  function automatic bit accepts(input int count, input int level);
    return count < level;
  endfunction

  task automatic mismatch(input string name, input int expected, input int actual);
    $display("** Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
    error_count++;
  endtask

  always @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      tx_exp.delete();
      rx_exp.delete();
      tx_cnt      = 0;
      rx_cnt      = 0;
      tx_busy     = 0;
      dec_cnt     = -1;
      rx_quiet    = 0;
      ferr_exp    = 0;
      ferr_seen   = 0;
      ovr_exp     = 0;
      ovr_seen    = 0;
      txd_prev    = 1'b1;
      rxd_prev    = 1'b1;
      error_count = 0;
      report_done = 1'b0;
      reset_checked = 1'b0;
    end else begin
      // flags first since they reflect the model before this edge
      if (!reset_checked) begin
        if (txd !== 1'b1) mismatch("txd", 1, int'(txd));
        if (status.tx_empty !== 1'b1)
          mismatch("status.tx_empty", 1, int'(status.tx_empty));
        if (status.rx_empty !== 1'b1)
          mismatch("status.rx_empty", 1, int'(status.rx_empty));
        reset_checked = 1'b1;
      end
      // no pops while tx is held off
      if (!tx_enable) begin
        if (status.tx_empty !== (tx_cnt == 0))
          mismatch("status.tx_empty", int'(tx_cnt == 0), int'(status.tx_empty));
        if (status.tx_full !== (tx_cnt == int'(tx_level)))
          mismatch("status.tx_full", int'(tx_cnt == int'(tx_level)), int'(status.tx_full));
      end
      // rx flags once the receiver write has settled
      if (rx_quiet > CPB) begin
        if (status.rx_empty !== (rx_cnt == 0))
          mismatch("status.rx_empty", int'(rx_cnt == 0), int'(status.rx_empty));
        if (status.rx_full !== (rx_cnt == int'(rx_level)))
          mismatch("status.rx_full", int'(rx_cnt == int'(rx_level)), int'(status.rx_full));
      end

      // host push
      if (tx_wr_en && accepts(tx_cnt, int'(tx_level))) begin
        tx_exp.push_back(tx_data);
        tx_cnt++;
      end
      // a start bit on txd means one pop
      if (tx_busy > 0) begin
        tx_busy--;
      end else if (txd_prev && !txd) begin
        tx_busy = FRAME - 2;
        tx_cnt--;
      end
      txd_prev = txd;

      // host pop with show-ahead data checked on the read edge
      if (rx_rd_en && rx_cnt > 0) begin
        exp_byte = rx_exp.pop_front();
        if (rx_data !== exp_byte) mismatch("rx_data", int'(exp_byte), int'(rx_data));
        rx_cnt--;
      end

      // line decoder with mid-bit samples counted from the falling edge
      if (dec_cnt < 0) begin
        if (rxd_prev && !rxd) dec_cnt = 0;
      end else begin
        dec_cnt++;
        if (dec_cnt > CPB && dec_cnt % CPB == CPB / 2) begin
          if (dec_cnt / CPB <= `UART_DATA_BITS) begin
            dec_byte = {rxd, dec_byte[`UART_DATA_BITS-1:1]};
          end else begin
            dec_cnt = -1;
            if (!rxd) begin
              ferr_exp++;
            end else begin
              if (loopback) begin
                if (tx_exp.size() == 0) begin
                  $display("frame seen on txd at %0t ns with no byte accepted to send", $time);
                  error_count++;
                end else begin
                  exp_byte = tx_exp.pop_front();
                  if (dec_byte !== exp_byte)
                    mismatch("txd byte", int'(exp_byte), int'(dec_byte));
                end
              end
              if (accepts(rx_cnt, int'(rx_level))) begin
                rx_exp.push_back(dec_byte);
                rx_cnt++;
              end else begin
                ovr_exp++;
              end
            end
          end
        end
      end
      rxd_prev = rxd;
      rx_quiet = (dec_cnt < 0) ? rx_quiet + 1 : 0;

      if (frame_error) ferr_seen++;
      if (rx_overrun) ovr_seen++;

      // closing tallies
      if (end_of_test && !report_done) begin
        if (ferr_seen != ferr_exp) mismatch("frame_error pulses", ferr_exp, ferr_seen);
        if (ovr_seen != ovr_exp) mismatch("rx_overrun pulses", ovr_exp, ovr_seen);
        if (tx_exp.size() != 0 || rx_exp.size() != 0) begin
          $display("bytes left undelivered at end of run: tx %0d, rx %0d",
                   tx_exp.size(), rx_exp.size());
          error_count++;
        end
        report_done = 1'b1;
      end
    end
  end

endmodule

// ==== hdl/uart_fifo_top.sv ====
// ****************************************
// uart peripheral top level
// host pushes tx bytes and pops rx bytes through two queues
// tx_level and rx_level set each queue's full point
// ****************************************
`timescale 1ns/100ps
`include "uart_cfg.svh"

module uart_fifo_top (
  input  logic                  clock,
  input  logic                  rst_n,
  input  logic                  tx_enable,
  input  logic                  tx_wr_en,
  input  uart_pkg::uart_byte_t  tx_data,
  input  uart_pkg::tx_level_t   tx_level,
  input  logic                  rx_rd_en,
  input  uart_pkg::rx_level_t   rx_level,
  output uart_pkg::uart_byte_t  rx_data,
  output uart_pkg::uart_status_t status,
  output logic                  frame_error,
  output logic                  rx_overrun,
  output logic                  txd,
  input  logic                  rxd
);

  // tx queue to transmitter
  logic                 tx_rd_en;
  uart_pkg::uart_byte_t tx_fifo_data;
  logic                 tx_empty;
  logic                 tx_full;

  // receiver to rx queue
  logic                 rx_wr_en;
  uart_pkg::uart_byte_t rx_fifo_data;
  logic                 rx_empty;
  logic                 rx_full;

  // host-facing transmit queue
  fifo #(
    .DATA_SIZE       (`UART_DATA_BITS),
    .DEPTH           (`UART_TX_DEPTH)
  ) i_tx_fifo (
    .clock           (clock),
    .rst_n           (rst_n),
    .wr_en           (tx_wr_en),
    .rd_en           (tx_rd_en),
    .watermark_level (tx_level),
    .wr_data         (tx_data),
    .rd_data         (tx_fifo_data),
    .empty           (tx_empty),
    .full            (tx_full)
  );

  // receive queue, drained by host reads
  fifo #(
    .DATA_SIZE       (`UART_DATA_BITS),
    .DEPTH           (`UART_RX_DEPTH)
  ) i_rx_fifo (
    .clock           (clock),
    .rst_n           (rst_n),
    .wr_en           (rx_wr_en),
    .rd_en           (rx_rd_en),
    .watermark_level (rx_level),
    .wr_data         (rx_fifo_data),
    .rd_data         (rx_data),
    .empty           (rx_empty),
    .full            (rx_full)
  );

  uart_tx i_uart_tx (
    .clock      (clock),
    .rst_n      (rst_n),
    .tx_enable  (tx_enable),
    .fifo_empty (tx_empty),
    .fifo_data  (tx_fifo_data),
    .fifo_rd_en (tx_rd_en),
    .txd        (txd)
  );

  uart_rx i_uart_rx (
    .clock       (clock),
    .rst_n       (rst_n),
    .rxd         (rxd),
    .fifo_full   (rx_full),
    .fifo_wr_en  (rx_wr_en),
    .fifo_data   (rx_fifo_data),
    .frame_error (frame_error),
    .rx_overrun  (rx_overrun)
  );

  // queue flags out to the host
  assign status.tx_empty = tx_empty;
  assign status.tx_full  = tx_full;
  assign status.rx_empty = rx_empty;
  assign status.rx_full  = rx_full;

endmodule

// ==== hdl/uart_rx.sv ====
// ****************************************
// 8n1 serial receiver
// two-flop sync, mid-bit sampling
// writes good bytes to the rx queue, flags frame error and overrun
// ****************************************
`timescale 1ns/100ps
`include "uart_cfg.svh"

module uart_rx (
  input  logic                 clock,
  input  logic                 rst_n,
  input  logic                 rxd,
  input  logic                 fifo_full,
  output logic                 fifo_wr_en,
  output uart_pkg::uart_byte_t fifo_data,
  output logic                 frame_error,
  output logic                 rx_overrun
);

  localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT + 1);
  localparam int IDX_W = $clog2(`UART_DATA_BITS);

  uart_pkg::rx_state_t  state;
  logic [CNT_W-1:0]     clk_cnt;
  logic [IDX_W-1:0]     bit_idx;
  uart_pkg::uart_byte_t shift_reg;

  // synchronizer plus one extra stage for edge detect
  logic                 rxd_meta;
  logic                 rxd_sync;
  logic                 rxd_prev;
  logic                 fall_edge;

  logic                 half_end;
  logic                 bit_end;
  logic                 stop_sample;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      // line idles high
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
    end
  end

  assign fall_edge = rxd_prev & ~rxd_sync;

  // half a bit into start, then full bits for data and stop
  assign half_end = (clk_cnt == CNT_W'(`UART_CLKS_PER_BIT / 2 - 1));
  assign bit_end  = (clk_cnt == CNT_W'(`UART_CLKS_PER_BIT - 1));

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      state   <= uart_pkg::RX_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
    end else begin
      case (state)
        uart_pkg::RX_IDLE: begin
          clk_cnt <= '0;
          if (fall_edge) begin
            state <= uart_pkg::RX_START;
          end
        end
        uart_pkg::RX_START: begin
          if (half_end) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            // high again at mid start bit, treat as glitch
            if (rxd_sync) begin
              state <= uart_pkg::RX_IDLE;
            end else begin
              state <= uart_pkg::RX_DATA;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        uart_pkg::RX_DATA: begin
          if (bit_end) begin
            clk_cnt <= '0;
            if (bit_idx == IDX_W'(`UART_DATA_BITS - 1)) begin
              state <= uart_pkg::RX_STOP;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        uart_pkg::RX_STOP: begin
          // back to idle right after the mid-bit sample
          if (bit_end) begin
            clk_cnt <= '0;
            state   <= uart_pkg::RX_IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= uart_pkg::RX_IDLE;
      endcase
    end
  end

  // lsb arrives first, shift in from the top
  always_ff @(posedge clock) begin
    if (state == uart_pkg::RX_DATA && bit_end) begin
      shift_reg <= {rxd_sync, shift_reg[`UART_DATA_BITS-1:1]};
    end
  end

  assign stop_sample = (state == uart_pkg::RX_STOP) && bit_end;

  // stop high: write, or drop on a full queue
  assign fifo_wr_en  = stop_sample && rxd_sync && !fifo_full;
  assign rx_overrun  = stop_sample && rxd_sync && fifo_full;
  // stop low: nothing written
  assign frame_error = stop_sample && !rxd_sync;
  assign fifo_data   = shift_reg;

endmodule

// ==== hdl/uart_tx.sv ====
// ****************************************
// 8n1 serial transmitter
// pops one byte from the tx queue per frame
// stalls in idle while tx_enable is low
// ****************************************
`timescale 1ns/100ps
`include "uart_cfg.svh"

module uart_tx (
  input  logic                clock,
  input  logic                rst_n,
  input  logic                tx_enable,
  input  logic                fifo_empty,
  input  uart_pkg::uart_byte_t fifo_data,
  output logic                fifo_rd_en,
  output logic                txd
);

  localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT + 1);
  localparam int IDX_W = $clog2(`UART_DATA_BITS);

  uart_pkg::tx_state_t  state;
  logic [CNT_W-1:0]     clk_cnt;
  logic [IDX_W-1:0]     bit_idx;
  uart_pkg::uart_byte_t shift_reg;
  logic                 bit_end;

  // last cycle of the current bit period
  assign bit_end = (clk_cnt == CNT_W'(`UART_CLKS_PER_BIT - 1));

  // single-cycle pop, only from idle
  assign fifo_rd_en = (state == uart_pkg::TX_IDLE) && tx_enable && !fifo_empty;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      state   <= uart_pkg::TX_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
    end else begin
      case (state)
        uart_pkg::TX_IDLE: begin
          clk_cnt <= '0;
          if (fifo_rd_en) begin
            state <= uart_pkg::TX_START;
          end
        end
        uart_pkg::TX_START: begin
          if (bit_end) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            state   <= uart_pkg::TX_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        uart_pkg::TX_DATA: begin
          if (bit_end) begin
            clk_cnt <= '0;
            // msb sent, go to stop
            if (bit_idx == IDX_W'(`UART_DATA_BITS - 1)) begin
              state <= uart_pkg::TX_STOP;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        uart_pkg::TX_STOP: begin
          if (bit_end) begin
            clk_cnt <= '0;
            state   <= uart_pkg::TX_IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= uart_pkg::TX_IDLE;
      endcase
    end
  end

  // capture on pop, shift lsb first
  always_ff @(posedge clock) begin
    if (fifo_rd_en) begin
      shift_reg <= fifo_data;
    end else if (state == uart_pkg::TX_DATA && bit_end) begin
      shift_reg <= shift_reg >> 1;
    end
  end

  // line level per state, idle and stop are high
  always_comb begin
    case (state)
      uart_pkg::TX_START: txd = 1'b0;
      uart_pkg::TX_DATA:  txd = shift_reg[0];
      default:            txd = 1'b1;
    endcase
  end

endmodule

// ==== hdl/fifo.sv ====
// ****************************************
// register-array queue with show-ahead read
// full means fill count == watermark_level
// depth must be a power of two
// ****************************************
`timescale 1ns/100ps

module fifo #(
  parameter int DATA_SIZE = 8,
  parameter int DEPTH     = 8
) (
  input  logic                     clock,
  input  logic                     rst_n,
  input  logic                     wr_en,
  input  logic                     rd_en,
  input  logic [$clog2(DEPTH)-1:0] watermark_level,
  input  logic [DATA_SIZE-1:0]     wr_data,
  output logic [DATA_SIZE-1:0]     rd_data,
  output logic                     empty,
  output logic                     full
);

  localparam int ADDR_W = $clog2(DEPTH);

  // pointers and occupancy
  logic [ADDR_W-1:0]    rd_ptr;
  logic [ADDR_W-1:0]    wr_ptr;
  logic [ADDR_W-1:0]    fill_count;

  // storage
  logic [DATA_SIZE-1:0] mem [DEPTH];

  // accepted transfers
  logic                 wr_accept;
  logic                 rd_accept;

  assign wr_accept = wr_en & ~full;
  assign rd_accept = rd_en & ~empty;

  // read pointer, advances on accepted read
  sync_parallel_counter #(
    .size       (ADDR_W),
    .init_value (0)
  ) i_rd_pointer (
    .clock      (clock),
    .rst_n      (rst_n),
    .load       (1'b0),
    .load_value (ADDR_W'(0)),
    .inc_enable (rd_accept),
    .dec_enable (1'b0),
    .value      (rd_ptr)
  );

  // write pointer, advances on accepted write
  sync_parallel_counter #(
    .size       (ADDR_W),
    .init_value (0)
  ) i_wr_pointer (
    .clock      (clock),
    .rst_n      (rst_n),
    .load       (1'b0),
    .load_value (ADDR_W'(0)),
    .inc_enable (wr_accept),
    .dec_enable (1'b0),
    .value      (wr_ptr)
  );

  // fill count, simultaneous push and pop leaves it unchanged
  sync_parallel_counter #(
    .size       (ADDR_W),
    .init_value (0)
  ) i_fill_count (
    .clock      (clock),
    .rst_n      (rst_n),
    .load       (1'b0),
    .load_value (ADDR_W'(0)),
    .inc_enable (wr_accept),
    .dec_enable (rd_accept),
    .value      (fill_count)
  );

  always_ff @(posedge clock) begin
    if (wr_accept) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // show-ahead, oldest entry always visible
  assign rd_data = mem[rd_ptr];

  assign empty = (fill_count == '0);
  // level of 0 blocks every write
  assign full  = (fill_count == watermark_level);

endmodule

// ==== hdl/sync_parallel_counter.sv ====
// ****************************************
// loadable up/down counter
// used for queue pointers and fill count
// ****************************************
`timescale 1ns/100ps

module sync_parallel_counter #(
  parameter int size       = 4,
  parameter int init_value = 0
) (
  input  logic            clock,
  input  logic            rst_n,
  input  logic            load,
  input  logic [size-1:0] load_value,
  input  logic            inc_enable,
  input  logic            dec_enable,
  output logic [size-1:0] value
);

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      value <= size'(init_value);
    end else if (load) begin
      // load wins over counting
      value <= load_value;
    end else if (inc_enable && !dec_enable) begin
      // wraps modulo 2^size
      value <= value + 1'b1;
    end else if (dec_enable && !inc_enable) begin
      value <= value - 1'b1;
    end
    // both or neither enable set, hold
  end

endmodule

// ==== hdl/uart_pkg.sv ====
// ****************************************
// shared types for the uart peripheral
// reference by scoped name, e.g. uart_pkg::uart_byte_t
// ****************************************
`include "uart_cfg.svh"

package uart_pkg;

  // one character
  typedef logic [`UART_DATA_BITS-1:0] uart_byte_t;

  // watermark and fill count width, log2 of depth
  typedef logic [$clog2(`UART_TX_DEPTH)-1:0] tx_level_t;
  typedef logic [$clog2(`UART_RX_DEPTH)-1:0] rx_level_t;

  // queue flags as seen by the host
  typedef struct packed {
    logic tx_empty;
    logic tx_full;
    logic rx_empty;
    logic rx_full;
  } uart_status_t;

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;
  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

endpackage

// ==== hdl/uart_cfg.svh ====
// ****************************************
// build-time sizing for the uart peripheral
// include wherever widths, depths or the bit period are needed
// ****************************************
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// character width, 8n1 framing
`define UART_DATA_BITS 8

// queue depths, powers of two only
`define UART_TX_DEPTH 8
`define UART_RX_DEPTH 16

// clock cycles per serial bit
// short on purpose so simulation stays fast
`define UART_CLKS_PER_BIT 8

`endif
